// ==== common/desc_dma_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types for the descriptor DMA frontend. Data width is fixed at 64
// bits, so a 32-byte descriptor is always read as four beats.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package desc_dma_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] len_t;
    typedef logic [31:0] flags_t;

    // all ones ends a chain
    localparam addr_t ADDR_SENTINEL = '1;

    localparam int unsigned BEATS_PER_DESC     = 4;
    localparam int unsigned INPUT_FIFO_DEPTH   = 8;
    localparam int unsigned PENDING_FIFO_DEPTH = 8;

    // register offsets
    localparam logic [7:0] REG_STATUS    = 8'h00;
    localparam logic [7:0] REG_DESC_ADDR = 8'h08;

    // low bit of each field in the flags word
    localparam int unsigned FLAG_IRQ          = 0;
    localparam int unsigned FLAG_SRC_BURST_LO = 1;
    localparam int unsigned FLAG_DST_BURST_LO = 3;
    localparam int unsigned FLAG_DECOUPLE     = 5;
    localparam int unsigned FLAG_DEBURST      = 7;
    localparam int unsigned FLAG_ID_LO        = 16;

    typedef struct packed {
        logic       valid;
        logic       write;
        logic [7:0] addr;
        data_t      wdata;
    } reg_req_t;

    // status has busy in bit 0 and fifo_full in bit 1
    typedef struct packed {
        logic  ready;
        data_t rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
    } mem_req_t;

    typedef struct packed {
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        logic  r_last;
        logic  aw_ready;
        logic  w_ready;
    } mem_rsp_t;

    typedef struct packed {
        len_t       length;
        addr_t      src_addr;
        addr_t      dst_addr;
        logic [7:0] axi_id;
        logic [1:0] src_burst;
        logic [1:0] dst_burst;
        logic       decouple_rw;
        logic       reduce_len;
    } be_req_t;

    typedef struct packed {
        logic  do_irq;
        addr_t desc_addr;
    } pend_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_SEND_AR,
        FETCH_WAIT_DATA,
        FETCH_SUBMIT
    } fetch_state_e;

    typedef enum logic [1:0] {
        CMPL_IDLE,
        CMPL_WAIT_BE,
        CMPL_SEND_AW,
        CMPL_SEND_W
    } complete_state_e;

endpackage

`default_nettype wire

// ==== logic/stream_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// Valid/ready FIFO with registered storage. Output is the head entry, so
// data_o is only meaningful while valid_o is high. No flush.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_fifo #(
    parameter int unsigned WIDTH = 64,
    parameter int unsigned DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o,
    input  logic             ready_i
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign ready_o = count_q != CNT_W'(DEPTH);
    assign valid_o = count_q != '0;
    assign data_o  = mem_q[rd_ptr_q];
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap at DEPTH, which need not be a power of two
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/desc_reg_port.sv ====
////////////////////////////////////////////////////////////////////////////
// Register port. A write to the address register waits for room in the
// input FIFO; everything else completes at once. Status lags one cycle.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_reg_port (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  desc_dma_pkg::reg_req_t  reg_req_i,
    output desc_dma_pkg::reg_rsp_t  reg_rsp_o,
    output desc_dma_pkg::addr_t     push_data_o,
    output logic                    push_valid_o,
    input  logic                    push_ready_i,
    input  logic                    fetch_busy_i,
    input  logic                    complete_busy_i,
    input  logic                    be_idle_i
);

    import desc_dma_pkg::*;

    logic       addr_write;
    logic [1:0] status_q;

    assign addr_write   = reg_req_i.valid && reg_req_i.write &&
                          (reg_req_i.addr == REG_DESC_ADDR);
    assign push_valid_o = addr_write;
    assign push_data_o  = reg_req_i.wdata;

    // only the address write can be held off
    assign reg_rsp_o.ready = addr_write ? push_ready_i : 1'b1;
    assign reg_rsp_o.rdata = (reg_req_i.addr == REG_STATUS) ? {62'b0, status_q} : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            status_q <= '0;
        end else begin
            status_q[0] <= fetch_busy_i || complete_busy_i || !be_idle_i;
            status_q[1] <= !push_ready_i;
        end
    end

endmodule

`default_nettype wire

// ==== fetch/desc_fetch.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor fetch engine. Reads a descriptor as one four-beat burst,
// submits it to the backend and the pending FIFO, then follows next until
// the all-ones sentinel. One descriptor is in the engine at a time.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_fetch (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  desc_dma_pkg::addr_t    addr_data_i,
    input  logic                   addr_valid_i,
    output logic                   addr_ready_o,
    input  desc_dma_pkg::mem_rsp_t mem_rsp_i,
    output logic                   ar_valid_o,
    output desc_dma_pkg::addr_t    ar_addr_o,
    output logic                   r_ready_o,
    output desc_dma_pkg::be_req_t  be_req_o,
    output logic                   be_req_valid_o,
    input  logic                   be_req_ready_i,
    output desc_dma_pkg::pend_t    pend_o,
    output logic                   pend_valid_o,
    input  logic                   pend_ready_i,
    output logic                   busy_o
);

    import desc_dma_pkg::*;

    fetch_state_e state_q;
    logic [1:0]   beat_q;
    logic         be_valid_q;
    logic         pend_valid_q;
    logic         r_hs;
    logic         last_beat;
    logic         submit_done;

    // descriptor being processed
    addr_t  cur_addr_q;
    len_t   desc_len_q;
    flags_t desc_flags_q;
    addr_t  desc_next_q;
    addr_t  desc_src_q;
    addr_t  desc_dst_q;

    assign addr_ready_o = state_q == FETCH_IDLE;
    assign ar_valid_o   = state_q == FETCH_SEND_AR;
    assign ar_addr_o    = cur_addr_q;
    assign r_ready_o    = state_q == FETCH_WAIT_DATA;
    assign busy_o       = state_q != FETCH_IDLE;

    assign r_hs      = (state_q == FETCH_WAIT_DATA) && mem_rsp_i.r_valid;
    assign last_beat = mem_rsp_i.r_last;

    // each valid may already have dropped on its own ready
    assign submit_done = (state_q == FETCH_SUBMIT) &&
                         (!be_valid_q || be_req_ready_i) &&
                         (!pend_valid_q || pend_ready_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= FETCH_IDLE;
            beat_q       <= '0;
            be_valid_q   <= 1'b0;
            pend_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (addr_valid_i) begin
                        state_q <= FETCH_SEND_AR;
                    end
                end
                FETCH_SEND_AR: begin
                    if (mem_rsp_i.ar_ready) begin
                        state_q <= FETCH_WAIT_DATA;
                        beat_q  <= '0;
                    end
                end
                FETCH_WAIT_DATA: begin
                    if (r_hs) begin
                        beat_q <= beat_q + 2'd1;
                        if (last_beat) begin
                            state_q      <= FETCH_SUBMIT;
                            be_valid_q   <= 1'b1;
                            pend_valid_q <= 1'b1;
                        end
                    end
                end
                FETCH_SUBMIT: begin
                    if (be_req_ready_i) begin
                        be_valid_q <= 1'b0;
                    end
                    if (pend_ready_i) begin
                        pend_valid_q <= 1'b0;
                    end
                    if (submit_done) begin
                        state_q <= (desc_next_q == ADDR_SENTINEL) ? FETCH_IDLE : FETCH_SEND_AR;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == FETCH_IDLE) && addr_valid_i) begin
            cur_addr_q <= addr_data_i;
        end else if (submit_done) begin
            cur_addr_q <= desc_next_q;
        end
        // beats carry len and flags, then next, src and dst
        if (r_hs) begin
            case (beat_q)
                2'd0: begin
                    desc_len_q   <= mem_rsp_i.r_data[31:0];
                    desc_flags_q <= mem_rsp_i.r_data[63:32];
                end
                2'd1: desc_next_q <= mem_rsp_i.r_data;
                2'd2: desc_src_q  <= mem_rsp_i.r_data;
                2'd3: desc_dst_q  <= mem_rsp_i.r_data;
                default: ;
            endcase
        end
    end

    // burst request built straight from the flags word
    assign be_req_o.length      = desc_len_q;
    assign be_req_o.src_addr    = desc_src_q;
    assign be_req_o.dst_addr    = desc_dst_q;
    assign be_req_o.axi_id      = desc_flags_q[FLAG_ID_LO +: 8];
    assign be_req_o.src_burst   = desc_flags_q[FLAG_SRC_BURST_LO +: 2];
    assign be_req_o.dst_burst   = desc_flags_q[FLAG_DST_BURST_LO +: 2];
    assign be_req_o.decouple_rw = desc_flags_q[FLAG_DECOUPLE];
    assign be_req_o.reduce_len  = desc_flags_q[FLAG_DEBURST];
    assign be_req_valid_o       = be_valid_q;

    assign pend_o.do_irq    = desc_flags_q[FLAG_IRQ];
    assign pend_o.desc_addr = cur_addr_q;
    assign pend_valid_o     = pend_valid_q;

endmodule

`default_nettype wire

// ==== completion/desc_complete.sv ====
////////////////////////////////////////////////////////////////////////////
// Completion engine. Pairs each pending entry with the next backend
// response, in order, then writes all ones to the descriptor's first word.
// The write response is not tracked.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_complete (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  desc_dma_pkg::pend_t    pend_i,
    input  logic                   pend_valid_i,
    output logic                   pend_ready_o,
    input  logic                   be_rsp_valid_i,
    output logic                   be_rsp_ready_o,
    input  desc_dma_pkg::mem_rsp_t mem_rsp_i,
    output logic                   aw_valid_o,
    output desc_dma_pkg::addr_t    aw_addr_o,
    output logic                   w_valid_o,
    output logic                   irq_o,
    output logic                   busy_o
);

    import desc_dma_pkg::*;

    complete_state_e state_q;
    pend_t           pend_q;
    logic            irq_q;

    assign pend_ready_o   = state_q == CMPL_IDLE;
    assign be_rsp_ready_o = state_q == CMPL_WAIT_BE;
    assign aw_valid_o     = state_q == CMPL_SEND_AW;
    assign w_valid_o      = state_q == CMPL_SEND_W;
    assign aw_addr_o      = pend_q.desc_addr;
    assign irq_o          = irq_q;
    assign busy_o         = state_q != CMPL_IDLE;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= CMPL_IDLE;
            irq_q   <= 1'b0;
        end else begin
            // single-cycle pulse by default
            irq_q <= 1'b0;
            case (state_q)
                CMPL_IDLE: begin
                    if (pend_valid_i) begin
                        state_q <= CMPL_WAIT_BE;
                    end
                end
                CMPL_WAIT_BE: begin
                    if (be_rsp_valid_i) begin
                        state_q <= CMPL_SEND_AW;
                    end
                end
                CMPL_SEND_AW: begin
                    if (mem_rsp_i.aw_ready) begin
                        state_q <= CMPL_SEND_W;
                    end
                end
                CMPL_SEND_W: begin
                    if (mem_rsp_i.w_ready) begin
                        state_q <= CMPL_IDLE;
                        irq_q   <= pend_q.do_irq;
                    end
                end
                default: state_q <= CMPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == CMPL_IDLE) && pend_valid_i) begin
            pend_q <= pend_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/desc_dma_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor DMA frontend top. Fetch drives the AR/R half of the memory
// bus and completion drives the AW/W half; they never share a channel.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_dma_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  desc_dma_pkg::reg_req_t reg_req_i,
    output desc_dma_pkg::reg_rsp_t reg_rsp_o,
    output desc_dma_pkg::mem_req_t mem_req_o,
    input  desc_dma_pkg::mem_rsp_t mem_rsp_i,
    output desc_dma_pkg::be_req_t  be_req_o,
    output logic                   be_req_valid_o,
    input  logic                   be_req_ready_i,
    input  logic                   be_rsp_valid_i,
    output logic                   be_rsp_ready_o,
    input  logic                   be_idle_i,
    output logic                   irq_o
);

    import desc_dma_pkg::*;

    // address queue
    addr_t in_push_data;
    logic  in_push_valid;
    logic  in_push_ready;
    addr_t in_pop_data;
    logic  in_pop_valid;
    logic  in_pop_ready;

    // pending queue
    pend_t pend_push_data;
    logic  pend_push_valid;
    logic  pend_push_ready;
    pend_t pend_pop_data;
    logic  pend_pop_valid;
    logic  pend_pop_ready;

    logic  fetch_busy;
    logic  complete_busy;

    desc_reg_port i_reg_port (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .reg_req_i       (reg_req_i),
        .reg_rsp_o       (reg_rsp_o),
        .push_data_o     (in_push_data),
        .push_valid_o    (in_push_valid),
        .push_ready_i    (in_push_ready),
        .fetch_busy_i    (fetch_busy),
        .complete_busy_i (complete_busy),
        .be_idle_i       (be_idle_i)
    );

    stream_fifo #(
        .WIDTH ($bits(addr_t)),
        .DEPTH (INPUT_FIFO_DEPTH)
    ) i_addr_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (in_push_data),
        .valid_i (in_push_valid),
        .ready_o (in_push_ready),
        .data_o  (in_pop_data),
        .valid_o (in_pop_valid),
        .ready_i (in_pop_ready)
    );

    desc_fetch i_fetch (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .addr_data_i    (in_pop_data),
        .addr_valid_i   (in_pop_valid),
        .addr_ready_o   (in_pop_ready),
        .mem_rsp_i      (mem_rsp_i),
        .ar_valid_o     (mem_req_o.ar_valid),
        .ar_addr_o      (mem_req_o.ar_addr),
        .r_ready_o      (mem_req_o.r_ready),
        .be_req_o       (be_req_o),
        .be_req_valid_o (be_req_valid_o),
        .be_req_ready_i (be_req_ready_i),
        .pend_o         (pend_push_data),
        .pend_valid_o   (pend_push_valid),
        .pend_ready_i   (pend_push_ready),
        .busy_o         (fetch_busy)
    );

    stream_fifo #(
        .WIDTH ($bits(pend_t)),
        .DEPTH (PENDING_FIFO_DEPTH)
    ) i_pend_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (pend_push_data),
        .valid_i (pend_push_valid),
        .ready_o (pend_push_ready),
        .data_o  (pend_pop_data),
        .valid_o (pend_pop_valid),
        .ready_i (pend_pop_ready)
    );

    desc_complete i_complete (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .pend_i         (pend_pop_data),
        .pend_valid_i   (pend_pop_valid),
        .pend_ready_o   (pend_pop_ready),
        .be_rsp_valid_i (be_rsp_valid_i),
        .be_rsp_ready_o (be_rsp_ready_o),
        .mem_rsp_i      (mem_rsp_i),
        .aw_valid_o     (mem_req_o.aw_valid),
        .aw_addr_o      (mem_req_o.aw_addr),
        .w_valid_o      (mem_req_o.w_valid),
        .irq_o          (irq_o),
        .busy_o         (complete_busy)
    );

endmodule

`default_nettype wire

// ==== bench/desc_mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// Behavioral memory for the DMA frontend bench. One read burst and one
// write at a time; ready stalls come in from the bench. Unloaded words
// read back as the inverted address.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_mem_model (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  desc_dma_pkg::mem_req_t mem_req_i,
    output desc_dma_pkg::mem_rsp_t mem_rsp_o,
    input  logic                   ar_stall_i,
    input  logic                   r_stall_i,
    input  logic                   aw_stall_i,
    input  logic                   w_stall_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import desc_dma_pkg::*;

    data_t      mem [addr_t];
    logic       rd_active_q;
    addr_t      rd_addr_q;
    logic [1:0] beat_q;
    data_t      r_data_q;
    logic       wr_pending_q;
    addr_t      wr_addr_q;

    assign mem_rsp_o.ar_ready = !rd_active_q && !ar_stall_i;
    assign mem_rsp_o.r_valid  = rd_active_q && !r_stall_i;
    assign mem_rsp_o.r_data   = r_data_q;
    assign mem_rsp_o.r_last   = beat_q == 2'(BEATS_PER_DESC - 1);
    assign mem_rsp_o.aw_ready = !wr_pending_q && !aw_stall_i;
    assign mem_rsp_o.w_ready  = wr_pending_q && !w_stall_i;

    function automatic data_t read_word(input addr_t a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    // preload from the bench
    task automatic load_word(input addr_t a, input data_t d);
        mem[a] = d;
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            rd_active_q  <= 1'b0;
            beat_q       <= '0;
            wr_pending_q <= 1'b0;
        end else begin
            if (mem_req_i.ar_valid && mem_rsp_o.ar_ready) begin
                rd_active_q <= 1'b1;
                rd_addr_q   <= mem_req_i.ar_addr;
                beat_q      <= '0;
                r_data_q    <= read_word(mem_req_i.ar_addr);
            end
            if (mem_req_i.r_ready && mem_rsp_o.r_valid) begin
                beat_q   <= beat_q + 2'd1;
                // prefetch the next 8-byte word of the burst
                r_data_q <= read_word(rd_addr_q + {59'b0, beat_q + 2'd1, 3'b0});
                if (mem_rsp_o.r_last) begin
                    rd_active_q <= 1'b0;
                end
            end
            if (mem_req_i.aw_valid && mem_rsp_o.aw_ready) begin
                wr_pending_q <= 1'b1;
                wr_addr_q    <= mem_req_i.aw_addr;
            end
            // completion mark lands on the W transfer
            if (mem_req_i.w_valid && mem_rsp_o.w_ready) begin
                mem[wr_addr_q] = '1;
                wr_pending_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/desc_dma_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Bench for the descriptor DMA frontend. Descriptors are listed in chain
// order; rows flagged first start a chain. Stalls come from one LFSR.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module desc_dma_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import desc_dma_pkg::*;

    typedef struct packed {
        logic   first;
        addr_t  addr;
        addr_t  next;
        len_t   len;
        addr_t  src;
        addr_t  dst;
        flags_t flags;
    } desc_row_t;

    localparam int    N_DESC = 13;
    localparam addr_t END    = ADDR_SENTINEL;

    // first, addr, next, length, source, destination, flags
    localparam desc_row_t TABLE [N_DESC] = '{
        '{1'b1, 64'h1000, 64'h1040, 32'h100, 64'h1_0000, 64'h2_0000, 32'h0001_0003},
        '{1'b0, 64'h1040, END,      32'h040, 64'h1_0100, 64'h2_0100, 32'h0002_0008},
        '{1'b1, 64'h2000, END,      32'h200, 64'h1_0200, 64'h2_0200, 32'h0003_0021},
        '{1'b1, 64'h2100, END,      32'h008, 64'h1_0300, 64'h2_0300, 32'h0004_0080},
        '{1'b1, 64'h2200, 64'h2240, 32'h010, 64'h1_0400, 64'h2_0400, 32'h0005_0015},
        '{1'b0, 64'h2240, 64'h2280, 32'h020, 64'h1_0500, 64'h2_0500, 32'h00ff_00ff},
        '{1'b0, 64'h2280, END,      32'h030, 64'h1_0600, 64'h2_0600, 32'h0000_0000},
        '{1'b1, 64'h3000, END,      32'h050, 64'h1_0700, 64'h2_0700, 32'h0010_0001},
        '{1'b1, 64'h3100, END,      32'h060, 64'h1_0800, 64'h2_0800, 32'h0011_0006},
        '{1'b1, 64'h3200, END,      32'h070, 64'h1_0900, 64'h2_0900, 32'h0012_0019},
        '{1'b1, 64'h3300, END,      32'h080, 64'h1_0a00, 64'h2_0a00, 32'h0013_00a1},
        '{1'b1, 64'h3400, END,      32'h090, 64'h1_0b00, 64'h2_0b00, 32'h0014_0000},
        '{1'b1, 64'h3500, END,      32'h0a0, 64'h1_0c00, 64'h2_0c00, 32'h0015_0001}
    };

    logic        clk_i = 1'b0;
    logic        reset_i;
    reg_req_t    reg_req;
    reg_rsp_t    reg_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    be_req_t     be_req;
    logic        be_req_valid;
    logic        be_req_ready;
    logic        be_rsp_valid;
    logic        be_rsp_ready;
    logic        be_idle;
    logic        irq;
    logic        ar_stall;
    logic        r_stall;
    logic        aw_stall;
    logic        w_stall;
    logic        be_hold;
    logic [31:0] lfsr = 32'd88576;
    int          be_idx = 0;
    int          rd_idx = 0;
    int          wr_idx = 0;
    int          rsp_count = 0;
    int          outstanding = 0;
    int          rsp_delay = 0;
    int          irq_count = 0;
    addr_t       aw_seen;

    always #20 clk_i = ~clk_i;

    desc_dma_top DUT (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .reg_req_i      (reg_req),
        .reg_rsp_o      (reg_rsp),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .be_req_o       (be_req),
        .be_req_valid_o (be_req_valid),
        .be_req_ready_i (be_req_ready),
        .be_rsp_valid_i (be_rsp_valid),
        .be_rsp_ready_o (be_rsp_ready),
        .be_idle_i      (be_idle),
        .irq_o          (irq)
    );

    desc_mem_model i_mem (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .mem_req_i  (mem_req),
        .mem_rsp_o  (mem_rsp),
        .ar_stall_i (ar_stall),
        .r_stall_i  (r_stall),
        .aw_stall_i (aw_stall),
        .w_stall_i  (w_stall)
    );

    // galois step per bit taken
    function automatic logic lfsr_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic be_req_t expect_be(input desc_row_t d);
        be_req_t b;
        b.length      = d.len;
        b.src_addr    = d.src;
        b.dst_addr    = d.dst;
        b.axi_id      = d.flags[23:16];
        b.src_burst   = d.flags[2:1];
        b.dst_burst   = d.flags[4:3];
        b.decouple_rw = d.flags[5];
        b.reduce_len  = d.flags[7];
        return b;
    endfunction

    task automatic check_equal(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_quiet_outputs();
        check_equal(256'({be_req_valid, be_rsp_ready, irq, mem_req.ar_valid,
                          mem_req.r_ready, mem_req.aw_valid, mem_req.w_valid}),
                    256'(0), "valid/ready outputs not low around reset");
    endtask

    task automatic push_addr(input addr_t a);
        logic accepted;
        reg_req  = '{valid: 1'b1, write: 1'b1, addr: REG_DESC_ADDR, wdata: a};
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = reg_rsp.ready;
        end
        @(negedge clk_i);
        reg_req = '0;
    endtask

    // hold the read across one edge so the registered status settles
    task automatic read_status(output data_t value);
        reg_req = '{valid: 1'b1, write: 1'b0, addr: REG_STATUS, wdata: '0};
        @(posedge clk_i);
        @(negedge clk_i);
        value   = reg_rsp.rdata;
        reg_req = '0;
    endtask

    always @(negedge clk_i) begin
        be_req_ready = !be_hold && (lfsr_bit() | lfsr_bit());
        ar_stall     = lfsr_bit() & lfsr_bit();
        r_stall      = lfsr_bit() & lfsr_bit();
        aw_stall     = lfsr_bit() & lfsr_bit();
        w_stall      = lfsr_bit() & lfsr_bit();
        be_rsp_valid = (outstanding > 0) && (rsp_delay == 0);
        be_idle      = outstanding == 0;
    end

    // bus monitors and backend bookkeeping
    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (mem_req.ar_valid && mem_rsp.ar_ready) begin
                check_equal(256'(mem_req.ar_addr), 256'(TABLE[rd_idx].addr), "read address");
                rd_idx++;
            end
            if (be_req_valid && be_req_ready) begin
                check_equal(256'(be_req), 256'(expect_be(TABLE[be_idx])), "burst request");
                be_idx++;
                outstanding++;
            end
            if (be_rsp_valid && be_rsp_ready) begin
                outstanding--;
                rsp_count++;
                rsp_delay = int'({lfsr_bit(), lfsr_bit()});
            end else if (rsp_delay > 0) begin
                rsp_delay--;
            end
            if (mem_req.aw_valid && mem_rsp.aw_ready) begin
                aw_seen = mem_req.aw_addr;
            end
            if (mem_req.w_valid && mem_rsp.w_ready) begin
                check_equal(256'(aw_seen), 256'(TABLE[wr_idx].addr), "completion address");
                check_equal(256'(rsp_count > wr_idx), 256'(1), "completion before response");
                wr_idx++;
            end
            if (irq) begin
                irq_count++;
            end
        end
    end

    initial begin
        int    exp_irq;
        int    pushes;
        data_t status;
        reset_i      = 1'b1;
        reg_req      = '0;
        be_hold      = 1'b1;
        be_req_ready = 1'b0;
        be_rsp_valid = 1'b0;
        be_idle      = 1'b1;
        ar_stall     = 1'b0;
        r_stall      = 1'b0;
        aw_stall     = 1'b0;
        w_stall      = 1'b0;
        exp_irq      = 0;
        pushes       = 0;
        for (int i = 0; i < N_DESC; i++) begin
            i_mem.load_word(TABLE[i].addr, {TABLE[i].flags, TABLE[i].len});
            i_mem.load_word(TABLE[i].addr + 64'd8, TABLE[i].next);
            i_mem.load_word(TABLE[i].addr + 64'd16, TABLE[i].src);
            i_mem.load_word(TABLE[i].addr + 64'd24, TABLE[i].dst);
            exp_irq += int'(TABLE[i].flags[0]);
        end
        repeat (8) begin
            @(negedge clk_i);
            check_quiet_outputs();
        end
        reset_i = 1'b0;
        @(negedge clk_i);
        check_quiet_outputs();

        for (int i = 0; i < N_DESC; i++) begin
            if (TABLE[i].first) begin
                // backend held off with one address in flight and the queue full
                if (pushes == INPUT_FIFO_DEPTH + 1) begin
                    read_status(status);
                    check_equal(256'(status), 256'(64'h3), "status while full");
                    reg_req = '{valid: 1'b1, write: 1'b1, addr: REG_DESC_ADDR,
                                wdata: TABLE[i].addr};
                    #1;
                    check_equal(256'(reg_rsp.ready), 256'(0), "register ready while full");
                    be_hold = 1'b0;
                end
                push_addr(TABLE[i].addr);
                pushes++;
            end
        end

        while (wr_idx < N_DESC || outstanding != 0) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        check_equal(256'(rd_idx), 256'(N_DESC), "descriptor read count");
        check_equal(256'(be_idx), 256'(N_DESC), "burst request count");
        check_equal(256'(irq_count), 256'(exp_irq), "interrupt count");
        read_status(status);
        check_equal(256'(status), 256'(64'h0), "status after drain");
        $display("All checks passed");
        $finish;
    end

    initial begin
        repeat (400 * N_DESC) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", 400 * N_DESC);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/desc_dma_pkg.sv
logic/stream_fifo.sv
logic/desc_reg_port.sv
fetch/desc_fetch.sv
completion/desc_complete.sv
logic/desc_dma_top.sv
bench/desc_mem_model.sv
bench/desc_dma_tb.sv

// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --timescale 1ns/1ps
TOP    = desc_dma_tb
FLIST  = flist.f
BUILD  = obj_dir
LOG    = sim.log
PASS   = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
